//--- logic/xosera_params.svh
`ifndef XOSERA_PARAMS_SVH
`define XOSERA_PARAMS_SVH

// bits per colour gun, red green and blue each
`define COLOR_BITS      4

// palette words, playfield A in the low half and B in the high half
`define PAL_ENTRIES     32

// interrupt sources, vsync and hsync start
`define NUM_INTR        2

`endif

//--- logic/xosera_bus_pkg.sv
`include "xosera_params.svh"

package xosera_bus_pkg;

    typedef logic [3:0]                         reg_num_t;      // cpu register number
    typedef logic [7:0]                         byte_t;         // one bus byte lane
    typedef logic [15:0]                        word_t;         // full register word
    typedef logic [$clog2(`PAL_ENTRIES)-1:0]    pal_addr_t;     // palette word address
    typedef logic [`NUM_INTR-1:0]               intr_t;         // one bit per source

    // cpu register map
    localparam reg_num_t REG_XR_ADDR    = 4'h0;     // palette address, auto-increments
    localparam reg_num_t REG_XR_DATA    = 4'h1;     // palette data port
    localparam reg_num_t REG_INT_CTRL   = 4'h2;     // even mask, odd clear / status

    // interrupt bit numbers
    localparam int VSYNC_INTR = 0;      // vsync start
    localparam int HSYNC_INTR = 1;      // hsync start

endpackage

//--- logic/xosera_video_pkg.sv
`include "xosera_params.svh"

package xosera_video_pkg;

    typedef logic [$clog2(`PAL_ENTRIES/2)-1:0]  color_t;    // playfield colour index
    typedef logic [15:0]                        argb_t;     // alpha in msb, rgb in 11:0
    typedef logic [3*`COLOR_BITS-1:0]           rgb_t;      // packed red, green, blue

    // overlay flag of a playfield B palette word
    localparam int ALPHA_BIT = 15;

endpackage

//--- logic/bus_decode.sv
module bus_decode(
    input  wire logic                       clk,
    input  wire logic                       reset_i,
    input  wire logic                       bus_cs_n_i,     // chip select, active low
    input  wire logic                       bus_rd_nwr_i,   // 1 read, 0 write
    input  wire xosera_bus_pkg::reg_num_t   bus_reg_num_i,  // register number
    input  wire logic                       bus_bytesel_i,  // 0 even byte, 1 odd byte
    input  wire xosera_bus_pkg::byte_t      bus_data_i,     // write data
    input  wire xosera_bus_pkg::intr_t      intr_status_i,  // pending bits for reads
    output xosera_bus_pkg::byte_t           bus_data_o,     // read data, held during cs
    output logic                            pal_wr_o,       // palette write strobe
    output xosera_bus_pkg::pal_addr_t       pal_addr_o,     // palette write address
    output xosera_bus_pkg::word_t           pal_data_o,     // palette write word
    output xosera_bus_pkg::intr_t           intr_mask_o,    // enabled sources
    output xosera_bus_pkg::intr_t           intr_clear_o    // one cycle clear strobe
);
    import xosera_bus_pkg::*;

    logic       cs_n_q;         // cs from the previous cycle
    logic       access;         // first cycle of an access
    logic       wr_even;        // write to an even byte
    logic       wr_odd;         // write to an odd byte
    byte_t      even_latch;     // high byte waiting for the odd byte
    pal_addr_t  xr_addr;        // XR_ADDR register
    byte_t      rd_data;        // read mux before the output register

    // one access per cs assertion, on the high to low step
    assign access   = cs_n_q & ~bus_cs_n_i;
    assign wr_even  = access & ~bus_rd_nwr_i & ~bus_bytesel_i;
    assign wr_odd   = access & ~bus_rd_nwr_i & bus_bytesel_i;

    always_comb begin
        rd_data = '0;
        case (bus_reg_num_i)
            REG_XR_ADDR: begin
                if (bus_bytesel_i) begin
                    rd_data = byte_t'(xr_addr);     // address lives in the odd byte
                end
            end
            REG_INT_CTRL: begin
                // even byte mask, odd byte pending
                rd_data = bus_bytesel_i ? byte_t'(intr_status_i) : byte_t'(intr_mask_o);
            end
            default: begin
                rd_data = '0;                       // XR_DATA and unused regs
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            cs_n_q          <= 1'b1;    // treat reset as deselected
            xr_addr         <= '0;
            intr_mask_o     <= '0;
            intr_clear_o    <= '0;
            pal_wr_o        <= 1'b0;
            bus_data_o      <= '0;
        end else begin
            cs_n_q          <= bus_cs_n_i;
            pal_wr_o        <= 1'b0;    // strobes default low
            intr_clear_o    <= '0;

            if (access && bus_rd_nwr_i) begin
                bus_data_o  <= rd_data; // captured once, held until next read
            end

            if (wr_even && bus_reg_num_i == REG_INT_CTRL) begin
                intr_mask_o <= intr_t'(bus_data_i);
            end

            if (wr_odd) begin
                case (bus_reg_num_i)
                    REG_XR_ADDR: begin
                        xr_addr         <= pal_addr_t'(bus_data_i);
                    end
                    REG_XR_DATA: begin
                        pal_wr_o        <= 1'b1;            // word commits on odd byte
                        xr_addr         <= xr_addr + 1'b1;  // wraps at palette end
                    end
                    REG_INT_CTRL: begin
                        intr_clear_o    <= intr_t'(bus_data_i);
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    // write payload, qualified by pal_wr_o downstream
    always_ff @(posedge clk) begin
        if (wr_even && bus_reg_num_i == REG_XR_DATA) begin
            even_latch  <= bus_data_i;                  // only the XR_DATA high byte
        end
        if (wr_odd) begin
            pal_addr_o  <= xr_addr;                     // address before increment
            pal_data_o  <= {even_latch, bus_data_i};
        end
    end

    // cs has to go high between accesses, so writes never merge
    pal_wr_single: assert property (@(posedge clk) disable iff (reset_i)
        pal_wr_o |=> !pal_wr_o)
        else $error("palette write strobe high two cycles");

endmodule

//--- logic/palette_lookup.sv
`include "xosera_params.svh"

module palette_lookup(
    input  wire logic                       clk,
    input  wire logic                       pal_wr_i,   // write strobe from bus decode
    input  wire xosera_bus_pkg::pal_addr_t  pal_addr_i, // write address
    input  wire xosera_bus_pkg::word_t      pal_data_i, // write word
    input  wire xosera_video_pkg::color_t   pix_a_i,    // playfield A index
    input  wire xosera_video_pkg::color_t   pix_b_i,    // playfield B index
    output xosera_video_pkg::argb_t         color_a_o,  // A colour, one cycle later
    output xosera_video_pkg::argb_t         color_b_o   // B colour, one cycle later
);
    import xosera_bus_pkg::*;
    import xosera_video_pkg::*;

    argb_t      pal_mem[`PAL_ENTRIES];  // shared A and B colour table
    pal_addr_t  rd_addr_a;
    pal_addr_t  rd_addr_b;

    // A in the lower half, B in the upper half
    assign rd_addr_a = {1'b0, pix_a_i};
    assign rd_addr_b = {1'b1, pix_b_i};

    always_ff @(posedge clk) begin
        if (pal_wr_i) begin
            pal_mem[pal_addr_i] <= argb_t'(pal_data_i);
        end
    end

    // registered reads, both playfields every cycle
    always_ff @(posedge clk) begin
        color_a_o <= pal_mem[rd_addr_a];
        color_b_o <= pal_mem[rd_addr_b];
    end

endmodule

//--- logic/pixel_output.sv
module pixel_output(
    input  wire logic                       clk,
    input  wire logic                       reset_i,
    input  wire logic                       vid_de_i,       // display enable at lookup
    input  wire logic                       vid_hsync_i,
    input  wire logic                       vid_vsync_i,
    input  wire xosera_video_pkg::argb_t    color_a_i,      // palette A result
    input  wire xosera_video_pkg::argb_t    color_b_i,      // palette B result
    output xosera_video_pkg::rgb_t          rgb_o,          // final colour
    output logic                            hsync_o,
    output logic                            vsync_o,
    output logic                            dv_de_o
);
    import xosera_video_pkg::*;

    logic   de_1;       // lined up with the palette read
    logic   hsync_1;
    logic   vsync_1;
    rgb_t   pix_rgb;    // overlay pick

    // B wins only where its alpha is set
    always_comb begin
        pix_rgb = color_a_i[$bits(rgb_t)-1:0];
        if (color_b_i[ALPHA_BIT]) begin
            pix_rgb = color_b_i[$bits(rgb_t)-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            de_1    <= 1'b0;
            hsync_1 <= 1'b0;
            vsync_1 <= 1'b0;
            rgb_o   <= '0;
            hsync_o <= 1'b0;
            vsync_o <= 1'b0;
            dv_de_o <= 1'b0;
        end else begin
            de_1    <= vid_de_i;                // stage 1, palette read in flight
            hsync_1 <= vid_hsync_i;
            vsync_1 <= vid_vsync_i;
            rgb_o   <= de_1 ? pix_rgb : '0;     // black outside display enable
            hsync_o <= hsync_1;                 // stage 2, all outputs together
            vsync_o <= vsync_1;
            dv_de_o <= de_1;
        end
    end

endmodule

//--- logic/intr_ctrl.sv
module intr_ctrl(
    input  wire logic                   clk,
    input  wire logic                   reset_i,
    input  wire logic                   vid_hsync_i,
    input  wire logic                   vid_vsync_i,
    input  wire xosera_bus_pkg::intr_t  intr_mask_i,    // enabled sources
    input  wire xosera_bus_pkg::intr_t  intr_clear_i,   // clear strobe from cpu
    output xosera_bus_pkg::intr_t       intr_status_o,  // pending sources
    output logic                        bus_intr_o      // one cycle cpu interrupt
);
    import xosera_bus_pkg::*;

    logic   hsync_q;    // previous sync levels for edge detect
    logic   vsync_q;
    intr_t  trigger;    // rising edges this cycle

    always_comb begin
        trigger             = '0;
        trigger[VSYNC_INTR] = vid_vsync_i & ~vsync_q;
        trigger[HSYNC_INTR] = vid_hsync_i & ~hsync_q;
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            hsync_q         <= 1'b0;
            vsync_q         <= 1'b0;
            intr_status_o   <= '0;
            bus_intr_o      <= 1'b0;
        end else begin
            hsync_q         <= vid_hsync_i;
            vsync_q         <= vid_vsync_i;
            // pulse only for enabled sources not yet pending
            bus_intr_o      <= |(trigger & intr_mask_i & ~intr_status_o);
            // new trigger beats a clear in the same cycle
            intr_status_o   <= (intr_status_o & ~intr_clear_i) | trigger;
        end
    end

    // each pulse comes with an enabled source that just went pending
    intr_pulse_new: assert property (@(posedge clk) disable iff (reset_i)
        bus_intr_o |-> |($past(intr_mask_i) & intr_status_o & ~$past(intr_status_o)))
        else $error("bus interrupt without a newly pending enabled source");

endmodule

//--- logic/xosera_display.sv
`include "xosera_params.svh"

module xosera_display(
    input  wire logic                       clk,            // pixel clock
    input  wire logic                       reset_i,
    input  wire logic                       bus_cs_n_i,     // register select, active low
    input  wire logic                       bus_rd_nwr_i,   // 1 read, 0 write
    input  wire xosera_bus_pkg::reg_num_t   bus_reg_num_i,
    input  wire logic                       bus_bytesel_i,  // 0 even, 1 odd
    input  wire xosera_bus_pkg::byte_t      bus_data_i,
    output xosera_bus_pkg::byte_t           bus_data_o,
    output logic                            bus_intr_o,     // cpu interrupt pulse
    input  wire logic                       vid_de_i,       // raw video timing in
    input  wire logic                       vid_hsync_i,
    input  wire logic                       vid_vsync_i,
    input  wire xosera_video_pkg::color_t   pix_a_i,        // playfield A index
    input  wire xosera_video_pkg::color_t   pix_b_i,        // playfield B index
    output logic [`COLOR_BITS-1:0]          red_o,
    output logic [`COLOR_BITS-1:0]          green_o,
    output logic [`COLOR_BITS-1:0]          blue_o,
    output logic                            hsync_o,
    output logic                            vsync_o,
    output logic                            dv_de_o
);
    import xosera_bus_pkg::*;
    import xosera_video_pkg::*;

    logic       pal_wr;         // palette write strobe
    pal_addr_t  pal_addr;
    word_t      pal_data;
    intr_t      intr_mask;      // even byte of INT_CTRL
    intr_t      intr_clear;     // odd byte write strobe
    intr_t      intr_status;    // odd byte read
    argb_t      color_a;        // palette outputs
    argb_t      color_b;
    rgb_t       rgb;            // packed output colour

    bus_decode bus_decode(
        .clk(clk),
        .reset_i(reset_i),
        .bus_cs_n_i(bus_cs_n_i),
        .bus_rd_nwr_i(bus_rd_nwr_i),
        .bus_reg_num_i(bus_reg_num_i),
        .bus_bytesel_i(bus_bytesel_i),
        .bus_data_i(bus_data_i),
        .intr_status_i(intr_status),
        .bus_data_o(bus_data_o),
        .pal_wr_o(pal_wr),
        .pal_addr_o(pal_addr),
        .pal_data_o(pal_data),
        .intr_mask_o(intr_mask),
        .intr_clear_o(intr_clear)
    );

    palette_lookup palette_lookup(
        .clk(clk),
        .pal_wr_i(pal_wr),
        .pal_addr_i(pal_addr),
        .pal_data_i(pal_data),
        .pix_a_i(pix_a_i),
        .pix_b_i(pix_b_i),
        .color_a_o(color_a),
        .color_b_o(color_b)
    );

    pixel_output pixel_output(
        .clk(clk),
        .reset_i(reset_i),
        .vid_de_i(vid_de_i),
        .vid_hsync_i(vid_hsync_i),
        .vid_vsync_i(vid_vsync_i),
        .color_a_i(color_a),
        .color_b_i(color_b),
        .rgb_o(rgb),
        .hsync_o(hsync_o),
        .vsync_o(vsync_o),
        .dv_de_o(dv_de_o)
    );

    intr_ctrl intr_ctrl(
        .clk(clk),
        .reset_i(reset_i),
        .vid_hsync_i(vid_hsync_i),
        .vid_vsync_i(vid_vsync_i),
        .intr_mask_i(intr_mask),
        .intr_clear_i(intr_clear),
        .intr_status_o(intr_status),
        .bus_intr_o(bus_intr_o)
    );

    assign {red_o, green_o, blue_o} = rgb;  // red in the top gun bits

endmodule

//--- tb/xosera_checker.sv
`include "xosera_params.svh"

module xosera_checker(
    input  wire logic                       clk,
    input  wire logic                       reset_i,
    input  wire logic                       cs_n_i,         // cpu bus as driven
    input  wire logic                       rd_nwr_i,
    input  wire xosera_bus_pkg::reg_num_t   reg_num_i,
    input  wire logic                       bytesel_i,
    input  wire xosera_bus_pkg::byte_t      wr_data_i,
    input  wire xosera_bus_pkg::byte_t      rd_data_i,      // dut bus_data_o
    input  wire logic                       intr_i,         // dut bus_intr_o
    input  wire logic                       de_i,           // raw video in
    input  wire logic                       hsync_i,
    input  wire logic                       vsync_i,
    input  wire xosera_video_pkg::color_t   pix_a_i,
    input  wire xosera_video_pkg::color_t   pix_b_i,
    input  wire xosera_video_pkg::rgb_t     rgb_i,          // red, green, blue joined
    input  wire logic [2:0]                 timing_i        // dv_de, hsync, vsync out
);
    timeunit 1ns;
    timeprecision 1ps;
    import xosera_bus_pkg::*;
    import xosera_video_pkg::*;

    string          test_name = "reset";    // current test, set from the testbench
    int             errors = 0;
    argb_t          pal[`PAL_ENTRIES];      // built from snooped XR_DATA writes
    logic           pal_wr_q = 1'b0;        // write lands one edge after the access
    pal_addr_t      pal_wr_addr;
    word_t          pal_wr_data;
    logic           cs_n_q;
    byte_t          even_q;                 // high byte waiting for the odd byte
    pal_addr_t      xr_addr;
    intr_t          mask, status, clear_q;  // clear_q acts one edge late
    logic           hsync_q, vsync_q;
    logic           exp_intr;
    logic           rd_live = 1'b0;         // read data held while cs stays low
    byte_t          exp_rd;
    logic [14:0]    stage1 = '0;            // {de, hsync, vsync, rgb}
    logic [14:0]    stage2 = '0;
    logic           live = 1'b0;            // outputs known after a reset edge

    task automatic compare_value(input string what, input logic [15:0] exp,
                                 input logic [15:0] act);
        if (exp !== act) begin
            errors++;
            $display("Error: %s %s expected %h actual %h", test_name, what, exp, act);
        end
    endtask

    // address in the odd byte, INT_CTRL even mask and odd pending
    function automatic byte_t expected_read(input reg_num_t num, input logic odd);
        byte_t val;
        val = 8'h00;
        if (num == REG_XR_ADDR && odd)
            val = byte_t'(xr_addr);
        else if (num == REG_INT_CTRL)
            val = odd ? byte_t'(status) : byte_t'(mask);
        return val;
    endfunction

    always @(posedge clk) begin
        logic       access;
        intr_t      trig;
        pal_addr_t  a_idx;
        pal_addr_t  b_idx;
        argb_t      col_b;
        rgb_t       pick;

        // outputs seen here are what the previous edge produced
        if (live) begin
            compare_value("rgb", 16'(stage2[11:0]), 16'(rgb_i));
            compare_value("de/sync", 16'(stage2[14:12]), 16'(timing_i));
            compare_value("bus_intr", 16'(exp_intr), 16'(intr_i));
            if (rd_live)
                compare_value("read data", 16'(exp_rd), 16'(rd_data_i));
        end
        if (reset_i)
            live = 1'b1;

        // lookups see the table as it was before this edge
        a_idx = pal_addr_t'(pix_a_i);
        b_idx = pal_addr_t'(`PAL_ENTRIES / 2 + int'(pix_b_i));  // B in the upper half
        col_b = pal[b_idx];
        pick = col_b[15] ? col_b[11:0] : pal[a_idx][11:0];     // B over A on alpha
        stage2 = reset_i ? '0 : stage1;
        stage1 = reset_i ? '0 : {de_i, hsync_i, vsync_i, de_i ? pick : 12'h000};
        if (pal_wr_q)
            pal[pal_wr_addr] = argb_t'(pal_wr_data);
        pal_wr_q = 1'b0;

        if (reset_i) begin
            cs_n_q = 1'b1;
            xr_addr = '0;
            mask = '0;
            status = '0;
            clear_q = '0;
            hsync_q = 1'b0;
            vsync_q = 1'b0;
            exp_intr = 1'b0;
            rd_live = 1'b0;
        end else begin
            access = cs_n_q & ~cs_n_i;  // first low cycle only
            if (cs_n_i)
                rd_live = 1'b0;
            if (access && rd_nwr_i) begin
                rd_live = 1'b1;
                exp_rd = expected_read(reg_num_i, bytesel_i);  // pre-edge state
            end
            trig = '0;
            trig[VSYNC_INTR] = vsync_i & ~vsync_q;
            trig[HSYNC_INTR] = hsync_i & ~hsync_q;
            exp_intr = |(trig & mask & ~status);    // new, enabled, not pending
            status = (status & ~clear_q) | trig;    // trigger wins over clear
            clear_q = '0;
            if (access && !rd_nwr_i && !bytesel_i) begin
                if (reg_num_i == REG_XR_DATA)
                    even_q = wr_data_i;
                if (reg_num_i == REG_INT_CTRL)
                    mask = intr_t'(wr_data_i);
            end
            if (access && !rd_nwr_i && bytesel_i) begin
                if (reg_num_i == REG_XR_ADDR)
                    xr_addr = pal_addr_t'(wr_data_i);
                if (reg_num_i == REG_INT_CTRL)
                    clear_q = intr_t'(wr_data_i);
                if (reg_num_i == REG_XR_DATA) begin
                    pal_wr_q = 1'b1;
                    pal_wr_addr = xr_addr;
                    pal_wr_data = {even_q, wr_data_i};
                    xr_addr = pal_addr_t'((int'(xr_addr) + 1) % `PAL_ENTRIES);
                end
            end
            cs_n_q = cs_n_i;
            hsync_q = hsync_i;
            vsync_q = vsync_i;
        end
    end

endmodule

//--- tb/tb_xosera.sv
`include "xosera_params.svh"

module tb_xosera;
    timeunit 1ns;
    timeprecision 1ps;
    import xosera_bus_pkg::*;
    import xosera_video_pkg::*;

    logic                   clk = 1'b0;
    logic                   reset_i;
    logic                   bus_cs_n_i, bus_rd_nwr_i, bus_bytesel_i;
    reg_num_t               bus_reg_num_i;
    byte_t                  bus_data_i, bus_data_o;
    logic                   bus_intr_o;
    logic                   vid_de_i, vid_hsync_i, vid_vsync_i;
    color_t                 pix_a_i, pix_b_i;
    logic [`COLOR_BITS-1:0] red_o, green_o, blue_o;
    logic                   hsync_o, vsync_o, dv_de_o;
    integer                 seed = 8;
    int                     passed = 0;
    int                     failed = 0;
    int                     timeouts = 0;
    int                     errors_seen = 0;    // errors counted at the last test end

    always #5 clk = ~clk;

    xosera_display uut(.*);

    xosera_checker chk(
        .clk(clk),
        .reset_i(reset_i),
        .cs_n_i(bus_cs_n_i),
        .rd_nwr_i(bus_rd_nwr_i),
        .reg_num_i(bus_reg_num_i),
        .bytesel_i(bus_bytesel_i),
        .wr_data_i(bus_data_i),
        .rd_data_i(bus_data_o),
        .intr_i(bus_intr_o),
        .de_i(vid_de_i),
        .hsync_i(vid_hsync_i),
        .vsync_i(vid_vsync_i),
        .pix_a_i(pix_a_i),
        .pix_b_i(pix_b_i),
        .rgb_i({red_o, green_o, blue_o}),
        .timing_i({dv_de_o, hsync_o, vsync_o})
    );

    // starts and ends 1 ns after an edge, cs low three cycles then high one
    task automatic bus_access(input logic rd, input reg_num_t num, input logic odd,
                              input byte_t data);
        bus_cs_n_i = 1'b0;
        bus_rd_nwr_i = rd;
        bus_reg_num_i = num;
        bus_bytesel_i = odd;
        bus_data_i = data;
        repeat (3) @(posedge clk);
        #1 bus_cs_n_i = 1'b1;
        @(posedge clk);
        #1;
    endtask

    task automatic write_palette(input word_t w);
        bus_access(1'b0, REG_XR_DATA, 1'b0, w[15:8]);  // latched
        bus_access(1'b0, REG_XR_DATA, 1'b1, w[7:0]);   // commits the word
    endtask

    task automatic drive_video(input int cycles);
        repeat (cycles) begin
            vid_de_i = 1'($random(seed));
            vid_hsync_i = 1'($random(seed));
            vid_vsync_i = 1'($random(seed));
            pix_a_i = color_t'($random(seed));
            pix_b_i = color_t'($random(seed));
            @(posedge clk);
            #1;
        end
        vid_de_i = 1'b0;
        vid_hsync_i = 1'b0;
        vid_vsync_i = 1'b0;
        repeat (2) @(posedge clk);  // let the pipe drain
        #1;
    endtask

    task automatic wait_intr();
        int n;
        logic seen;
        n = 0;
        do begin
            @(posedge clk);
            #1;
            seen = bus_intr_o;      // settled value after the edge
            n++;
        end while (seen !== 1'b1 && n < 1000);
        if (seen !== 1'b1) begin
            timeouts++;
            $display("timeout: no bus interrupt pulse within 1000 cycles");
        end
    endtask

    task automatic start_test(input string name);
        chk.test_name = name;
    endtask

    task automatic finish_test(input string name);
        int errs;
        errs = chk.errors + timeouts - errors_seen;
        errors_seen = chk.errors + timeouts;
        if (errs == 0) begin
            passed++;
            $display("test %s: ok", name);
        end else begin
            failed++;
            $display("test %s: failed with %0d errors", name, errs);
        end
    endtask

    initial begin
        word_t w;

        bus_cs_n_i = 1'b1;
        bus_rd_nwr_i = 1'b1;
        bus_reg_num_i = '0;
        bus_bytesel_i = 1'b0;
        bus_data_i = '0;
        vid_de_i = 1'b0;
        vid_hsync_i = 1'b0;
        vid_vsync_i = 1'b0;
        pix_a_i = '0;
        pix_b_i = '0;
        reset_i = 1'b1;
        repeat (8) @(posedge clk);
        #1 reset_i = 1'b0;

        bus_access(1'b1, REG_INT_CTRL, 1'b1, 8'h00);   // pending
        bus_access(1'b1, REG_INT_CTRL, 1'b0, 8'h00);   // mask
        bus_access(1'b1, REG_XR_ADDR, 1'b1, 8'h00);
        finish_test("reset");

        start_test("palette write");
        bus_access(1'b0, REG_XR_ADDR, 1'b1, 8'h00);
        for (int i = 0; i < `PAL_ENTRIES; i++) begin
            w = word_t'($random(seed));
            if (i >= `PAL_ENTRIES / 2)
                w[15] = 1'b0;                           // B see-through for now
            write_palette(w);
        end
        bus_access(1'b1, REG_XR_ADDR, 1'b1, 8'h00);    // wrapped to 0
        bus_access(1'b0, REG_XR_ADDR, 1'b1, 8'h05);
        w = word_t'($random(seed));
        bus_access(1'b0, REG_XR_DATA, 1'b0, w[15:8]);
        bus_access(1'b0, REG_XR_ADDR, 1'b0, ~w[15:8]); // other even byte, latch kept
        bus_access(1'b0, REG_XR_DATA, 1'b1, w[7:0]);
        bus_access(1'b1, REG_XR_ADDR, 1'b1, 8'h00);    // now 6
        finish_test("palette write");

        start_test("playfield A");
        drive_video(300);
        finish_test("playfield A");

        start_test("overlay");
        bus_access(1'b0, REG_XR_ADDR, 1'b1, 8'(`PAL_ENTRIES / 2));
        repeat (`PAL_ENTRIES / 2) write_palette(word_t'($random(seed)));  // random alpha
        drive_video(300);
        finish_test("overlay");

        start_test("interrupts");
        repeat (8) begin
            bus_access(1'b0, REG_INT_CTRL, 1'b0, byte_t'($random(seed)));
            drive_video(20);
            bus_access(1'b1, REG_INT_CTRL, 1'b1, 8'h00);
            bus_access(1'b0, REG_INT_CTRL, 1'b1, byte_t'($random(seed)));
            bus_access(1'b1, REG_INT_CTRL, 1'b1, 8'h00);
        end
        // both syncs rise in the cycle the clear strobe acts
        fork
            bus_access(1'b0, REG_INT_CTRL, 1'b1, 8'hff);
            begin
                @(posedge clk);
                #1;
                vid_vsync_i = 1'b1;
                vid_hsync_i = 1'b1;
            end
        join
        bus_access(1'b1, REG_INT_CTRL, 1'b1, 8'h00);
        vid_vsync_i = 1'b0;
        vid_hsync_i = 1'b0;
        bus_access(1'b0, REG_INT_CTRL, 1'b0, 8'h03);
        bus_access(1'b0, REG_INT_CTRL, 1'b1, 8'hff);
        vid_vsync_i = 1'b1;
        wait_intr();
        vid_vsync_i = 1'b0;
        bus_access(1'b1, REG_INT_CTRL, 1'b1, 8'h00);
        finish_test("interrupts");

        $display("tests: %0d passed, %0d failed", passed, failed);
        if (failed == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- files.f
+incdir+logic
logic/xosera_bus_pkg.sv
logic/xosera_video_pkg.sv
logic/bus_decode.sv
logic/palette_lookup.sv
logic/pixel_output.sv
logic/intr_ctrl.sv
logic/xosera_display.sv
tb/xosera_checker.sv
tb/tb_xosera.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP       = tb_xosera
FILELIST  = files.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
